// ==== rtl/cnn_add_pkg.sv ====
package cnn_add_pkg;

  //////////////////////////////////////////////////
  // Stream sizing

  // One feature value per word
  localparam int DATA_WIDTH = 32;

  // Feature value as carried on every stream
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Skip values allowed to wait at once
  localparam int FIFO_DEPTH = 16;
  // Pointer width for the skip buffer
  localparam int FIFO_AW    = 4;

  // Adder cycles, qualified operands to result
  localparam int ADD_LATENCY = 3;

  //////////////////////////////////////////////////
  // binary32 layout

  localparam int EXP_BITS = 8;
  localparam int MAN_BITS = 23;

  // Canonical quiet NaN
  localparam data_t QNAN = 32'h7FC0_0000;

endpackage

// ==== rtl/stream_delay.sv ====
`timescale 1ns/1ps

module stream_delay #(
  parameter type payload_t = cnn_add_pkg::data_t
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     valid_in,
  input  payload_t in,
  output payload_t out,
  output logic     valid_out
);

  // Payload held until the next strobe
  always_ff @(posedge clk) begin
    if (valid_in) begin
      out <= in;
    end
  end

  // Strobe follows one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

endmodule

// ==== rtl/skip_fifo.sv ====
`timescale 1ns/1ps

module skip_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               wr_en,
  input  logic               rd_en,
  input  cnn_add_pkg::data_t din,
  output cnn_add_pkg::data_t dout
);

  import cnn_add_pkg::*;

  // Circular storage
  data_t mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;

  logic full;
  logic empty;
  logic do_wr;
  logic do_rd;

  assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Write ignored when full
  assign do_wr = wr_en && !full;
  // Read of an empty buffer only with a write in the same cycle
  assign do_rd = rd_en && (!empty || do_wr);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Registered read port
  // Empty buffer hands the incoming word straight through
  always_ff @(posedge clk) begin
    if (do_rd) begin
      dout <= empty ? din : mem[rd_ptr];
    end
  end

  // Pointers wrap on the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/fp32_add.sv ====
`timescale 1ns/1ps

module fp32_add (
  input  logic               clk,
  input  logic               reset,
  input  logic               a_valid,
  input  cnn_add_pkg::data_t a,
  input  logic               b_valid,
  input  cnn_add_pkg::data_t b,
  output cnn_add_pkg::data_t result,
  output logic               result_valid
);

  import cnn_add_pkg::*;

  // Significand with hidden bit, then with guard, round, sticky
  localparam int SIG_W = MAN_BITS + 1;
  localparam int EXT_W = SIG_W + 3;

  localparam logic [EXP_BITS-1:0] EXP_MAX = {EXP_BITS{1'b1}};

  // Exponent with room for carry and cancellation
  typedef logic signed [EXP_BITS+1:0] sexp_t;

  // Aligned operands, larger magnitude first
  typedef struct packed {
    logic                sub;
    logic                sign;
    logic [EXP_BITS-1:0] exp;
    logic [SIG_W-1:0]    sig_l;
    logic [EXT_W-1:0]    sig_s;
    logic                is_nan;
    logic                is_inf;
    logic                inf_sign;
  } s1_t;

  // Normalized sum, not yet rounded
  typedef struct packed {
    logic                sign;
    sexp_t               exp;
    logic [EXT_W-1:0]    mant;
    logic                zero;
    logic                is_nan;
    logic                is_inf;
    logic                inf_sign;
  } s2_t;

  // Sum needs its top bit
  function automatic logic [4:0] lead_zeros(input logic [EXT_W:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'(EXT_W + 1);
    found = 1'b0;
    for (int i = EXT_W; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = 5'(EXT_W - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // Three register stages only
  if (ADD_LATENCY != 3) begin : g_latency_check
    $error("fp32_add pipeline depth does not match ADD_LATENCY");
  end

  //////////////////////////////////////////////////
  // Stage 1 unpack, specials, swap, align

  logic                sign_a;
  logic                sign_b;
  logic [EXP_BITS-1:0] exp_a;
  logic [EXP_BITS-1:0] exp_b;
  logic [MAN_BITS-1:0] man_a;
  logic [MAN_BITS-1:0] man_b;
  logic                zero_a;
  logic                zero_b;
  logic                inf_a;
  logic                inf_b;
  logic                nan_a;
  logic                nan_b;
  logic [SIG_W-1:0]    sig_a;
  logic [SIG_W-1:0]    sig_b;
  logic [DATA_WIDTH-2:0] mag_a;
  logic [DATA_WIDTH-2:0] mag_b;
  logic                swap;

  assign sign_a = a[DATA_WIDTH-1];
  assign sign_b = b[DATA_WIDTH-1];
  assign exp_a  = a[DATA_WIDTH-2 -: EXP_BITS];
  assign exp_b  = b[DATA_WIDTH-2 -: EXP_BITS];
  assign man_a  = a[MAN_BITS-1:0];
  assign man_b  = b[MAN_BITS-1:0];

  // Zero exponent covers subnormals, flushed here
  assign zero_a = (exp_a == '0);
  assign zero_b = (exp_b == '0);
  assign inf_a  = (exp_a == EXP_MAX) && (man_a == '0);
  assign inf_b  = (exp_b == EXP_MAX) && (man_b == '0);
  assign nan_a  = (exp_a == EXP_MAX) && (man_a != '0);
  assign nan_b  = (exp_b == EXP_MAX) && (man_b != '0);

  assign sig_a = zero_a ? '0 : {1'b1, man_a};
  assign sig_b = zero_b ? '0 : {1'b1, man_b};

  // Magnitude order, exponent and mantissa together
  assign mag_a = zero_a ? '0 : a[DATA_WIDTH-2:0];
  assign mag_b = zero_b ? '0 : b[DATA_WIDTH-2:0];
  assign swap  = (mag_b > mag_a);

  s1_t  s1_d;
  s1_t  s1_q;
  logic s1_valid;

  always_comb begin
    logic [EXT_W-1:0]    small_ext;
    logic [EXT_W-1:0]    shifted;
    logic [EXT_W-1:0]    lost_mask;
    logic [EXP_BITS-1:0] diff;
    small_ext = {swap ? sig_a : sig_b, 3'b000};
    diff      = swap ? (exp_b - exp_a) : (exp_a - exp_b);
    shifted   = small_ext >> diff;
    // Bits pushed past the sticky position
    lost_mask = ~({EXT_W{1'b1}} << diff);

    s1_d.sub      = sign_a ^ sign_b;
    s1_d.sign     = swap ? sign_b : sign_a;
    s1_d.exp      = swap ? exp_b : exp_a;
    s1_d.sig_l    = swap ? sig_b : sig_a;
    s1_d.sig_s    = {shifted[EXT_W-1:1], shifted[0] | (|(small_ext & lost_mask))};
    // NaN in, or opposite infinities
    s1_d.is_nan   = nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b));
    s1_d.is_inf   = inf_a || inf_b;
    s1_d.inf_sign = inf_a ? sign_a : sign_b;
  end

  // Operands start only as a pair
  stream_delay #(.payload_t(s1_t)) u_stage1 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (a_valid & b_valid),
    .in       (s1_d),
    .out      (s1_q),
    .valid_out(s1_valid)
  );

  //////////////////////////////////////////////////
  // Stage 2 add or subtract, normalize

  s2_t  s2_d;
  s2_t  s2_q;
  logic s2_valid;

  always_comb begin
    logic [EXT_W:0] sum;
    logic [EXT_W:0] norm;
    logic [4:0]     lz;
    // Larger first, so subtraction never goes negative
    if (s1_q.sub) begin
      sum = {1'b0, s1_q.sig_l, 3'b000} - {1'b0, s1_q.sig_s};
    end else begin
      sum = {1'b0, s1_q.sig_l, 3'b000} + {1'b0, s1_q.sig_s};
    end
    lz   = lead_zeros(sum);
    // Leading one moves to the top bit
    norm = sum << lz;

    // Exact cancellation gives +0
    s2_d.sign     = (s1_q.sub && (sum == '0)) ? 1'b0 : s1_q.sign;
    // Carry out leaves lz at zero, one above the large exponent
    s2_d.exp      = sexp_t'(s1_q.exp) + sexp_t'(1) - sexp_t'(lz);
    s2_d.mant     = {norm[EXT_W:2], norm[1] | norm[0]};
    s2_d.zero     = (sum == '0);
    s2_d.is_nan   = s1_q.is_nan;
    s2_d.is_inf   = s1_q.is_inf;
    s2_d.inf_sign = s1_q.inf_sign;
  end

  stream_delay #(.payload_t(s2_t)) u_stage2 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (s1_valid),
    .in       (s2_d),
    .out      (s2_q),
    .valid_out(s2_valid)
  );

  //////////////////////////////////////////////////
  // Stage 3 round, range check, pack

  data_t result_d;

  always_comb begin
    logic             round_up;
    logic [SIG_W:0]   rounded;
    sexp_t            exp_r;
    // Nearest even on guard, round, sticky
    round_up = s2_q.mant[2] & (s2_q.mant[1] | s2_q.mant[0] | s2_q.mant[3]);
    rounded  = {1'b0, s2_q.mant[EXT_W-1:3]} + (SIG_W+1)'(round_up);
    // Round carry bumps the exponent, mantissa already zero
    exp_r    = s2_q.exp + sexp_t'(rounded[SIG_W]);

    if (s2_q.is_nan) begin
      result_d = QNAN;
    end else if (s2_q.is_inf) begin
      result_d = {s2_q.inf_sign, EXP_MAX, {MAN_BITS{1'b0}}};
    end else if (s2_q.zero || (exp_r < sexp_t'(1))) begin
      // Underflow flushed, sign kept
      result_d = {s2_q.sign, {(DATA_WIDTH-1){1'b0}}};
    end else if (exp_r >= sexp_t'(EXP_MAX)) begin
      result_d = {s2_q.sign, EXP_MAX, {MAN_BITS{1'b0}}};
    end else begin
      result_d = {s2_q.sign, exp_r[EXP_BITS-1:0], rounded[MAN_BITS-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      result <= result_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= s2_valid;
    end
  end

endmodule

// ==== rtl/cnn_add_layer3.sv ====
`timescale 1ns/1ps

module cnn_add_layer3 (
  input  logic               clk,
  input  logic               reset,
  input  logic               valid_in_no1,
  input  cnn_add_pkg::data_t in_no1,
  input  logic               valid_in_no2,
  input  cnn_add_pkg::data_t in_no2,
  output cnn_add_pkg::data_t out,
  output logic               valid_out
);

  import cnn_add_pkg::*;

  //////////////////////////////////////////////////
  // Main path

  data_t main_data;
  logic  main_valid;

  // One cycle, to meet the buffer read data
  stream_delay #(.payload_t(data_t)) u_main_delay (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no1),
    .in       (in_no1),
    .out      (main_data),
    .valid_out(main_valid)
  );

  //////////////////////////////////////////////////
  // Skip path

  data_t skip_data;
  logic  skip_valid;

  // Skip values queue up, each main strobe pops one
  skip_fifo u_skip_fifo (
    .clk  (clk),
    .reset(reset),
    .wr_en(valid_in_no2),
    .rd_en(valid_in_no1),
    .din  (in_no2),
    .dout (skip_data)
  );

  // Read data is registered, strobe tracks it
  always_ff @(posedge clk) begin
    if (reset) begin
      skip_valid <= 1'b0;
    end else begin
      skip_valid <= valid_in_no1;
    end
  end

  //////////////////////////////////////////////////
  // Residual sum

  // Both halves arrive in the same cycle
  fp32_add u_add (
    .clk         (clk),
    .reset       (reset),
    .a_valid     (main_valid),
    .a           (main_data),
    .b_valid     (skip_valid),
    .b           (skip_data),
    .result      (out),
    .result_valid(valid_out)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Reset held over the first three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== test/cnn_add_layer3_assertions.sv ====
`timescale 1ns/1ps

module cnn_add_layer3_assertions (
  input logic                         clk,
  input logic                         reset,
  input logic                         valid_in_no1,
  input logic                         valid_in_no2,
  input logic                         main_valid,
  input logic                         skip_valid,
  input logic                         valid_out,
  input logic [cnn_add_pkg::FIFO_AW:0] fifo_count
);

  import cnn_add_pkg::*;

  // Pop needs a waiting value or a same-cycle write
  assert property (@(posedge clk) disable iff (reset)
    (valid_in_no1 && fifo_count == '0) |-> valid_in_no2)
    else $error("pop from an empty skip buffer");

  // Overflow of the skip buffer
  assert property (@(posedge clk) disable iff (reset)
    !(valid_in_no2 && fifo_count == (FIFO_AW+1)'(FIFO_DEPTH)))
    else $error("write into a full skip buffer");

  // Synchronous reset leaves every strobe low and the buffer empty
  assert property (@(posedge clk)
    reset |=> (!main_valid && !skip_valid && !valid_out && fifo_count == '0))
    else $error("reset did not clear the strobes and the skip buffer");

  // Four cycles input to output, unless a reset cut the pipeline
  assert property (@(posedge clk) disable iff (reset)
    (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3) && !$past(reset, 4))
    |-> (valid_out == $past(valid_in_no1, 4)))
    else $error("valid_out latency wrong");

endmodule

bind cnn_add_layer3 cnn_add_layer3_assertions u_assertions (
  .clk         (clk),
  .reset       (reset),
  .valid_in_no1(valid_in_no1),
  .valid_in_no2(valid_in_no2),
  .main_valid  (main_valid),
  .skip_valid  (skip_valid),
  .valid_out   (valid_out),
  .fifo_count  (u_skip_fifo.count)
);

// ==== test/tb_cnn_add_layer3.sv ====
`timescale 1ns/1ps

module tb_cnn_add_layer3;

  import cnn_add_pkg::*;

  // Rough cycle budget of all six tests
  localparam int TEST_CYCLES = 70 + 50 + 40 + 220 + 40 + 40;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

  logic  clk;
  logic  gen_reset;
  logic  tb_reset;
  logic  reset;
  logic  valid_in_no1;
  data_t in_no1;
  logic  valid_in_no2;
  data_t in_no2;
  data_t out;
  logic  valid_out;

  int          cycle;
  int          errors;
  int          checks;
  logic [31:0] seed;
  data_t       skip_model[$];
  data_t       exp_q[$];
  int          cyc_q[$];

  assign reset = gen_reset | tb_reset;

  tb_clock_gen u_clock_gen (
    .clk  (clk),
    .reset(gen_reset)
  );

  cnn_add_layer3 u_cnn_add_layer3 (
    .clk         (clk),
    .reset       (reset),
    .valid_in_no1(valid_in_no1),
    .in_no1      (in_no1),
    .valid_in_no2(valid_in_no2),
    .in_no2      (in_no2),
    .out         (out),
    .valid_out   (valid_out)
  );

  //////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // binary32 to binary64 bits, subnormals to signed zero
  function automatic logic [63:0] widen(input data_t f);
    logic [10:0] e;
    if (f[30:23] == '0) return {f[31], 63'b0};
    e = {3'b000, f[30:23]} + 11'd896;
    return {f[31], e, f[22:0], 29'b0};
  endfunction

  // binary64 to binary32, nearest even, flush and overflow
  function automatic data_t narrow(input logic [63:0] d);
    logic        sign;
    logic [24:0] keep;
    logic        guard;
    logic        sticky;
    int          fe;
    sign = d[63];
    if (d[62:52] == '0) return {sign, 31'b0};
    fe     = int'(d[62:52]) - 1023 + 127;
    keep   = {2'b01, d[51:29]};
    guard  = d[28];
    sticky = |d[27:0];
    if (guard && (sticky || keep[0])) keep = keep + 25'd1;
    if (keep[24]) begin
      fe   = fe + 1;
      keep = keep >> 1;
    end
    if (fe >= 255) return {sign, 8'hFF, 23'b0};
    if (fe < 1) return {sign, 31'b0};
    return {sign, fe[7:0], keep[22:0]};
  endfunction

  function automatic data_t ref_add(input data_t x, input data_t y);
    logic x_inf;
    logic y_inf;
    real  r;
    x_inf = (x[30:23] == 8'hFF) && (x[22:0] == '0);
    y_inf = (y[30:23] == 8'hFF) && (y[22:0] == '0);
    if ((x[30:23] == 8'hFF && !x_inf) || (y[30:23] == 8'hFF && !y_inf)) return QNAN;
    if (x_inf && y_inf && (x[31] != y[31])) return QNAN;
    if (x_inf) return x;
    if (y_inf) return y;
    r = $bitstoreal(widen(x)) + $bitstoreal(widen(y));
    return narrow($realtobits(r));
  endfunction

  // Normal operand within a 40-binade window
  function automatic data_t rand_operand();
    logic [31:0] r;
    r = lcg_next();
    return {r[31], 8'(107 + (r[30:23] % 40)), r[22:0]};
  endfunction

  //////////////////////////////////////////////////
  // Drive, drain, report

  // One clock cycle of stimulus on both streams
  task automatic drive_cycle(input logic wr, input data_t wv, input logic rd, input data_t rv);
    @(posedge clk);
    valid_in_no2 <= wr;
    in_no2       <= wv;
    valid_in_no1 <= rd;
    in_no1       <= rv;
    if (wr) skip_model.push_back(wv);
    if (rd) begin
      exp_q.push_back(ref_add(rv, skip_model.pop_front()));
      cyc_q.push_back(cycle);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
  endtask

  // Until every expected result has come out
  task automatic drain();
    while (exp_q.size() != 0) idle(1);
    idle(2);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) $display("test %s: passed", name);
    else $display("test %s: failed with %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////
  // Monitor and timeout

  always @(negedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  always @(negedge clk) begin
    data_t e;
    int    c;
    if (!reset && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output %h at time %0t with no result pending", out, $time);
        errors = errors + 1;
      end else begin
        e = exp_q.pop_front();
        c = cyc_q.pop_front();
        checks = checks + 1;
        assert (out === e)
          else begin
            $display("MISMATCH at %0t: expected %h, got %h", $time, e, out);
            errors = errors + 1;
          end
        assert (cycle - c == 4)
          else begin
            $display("MISMATCH at %0t: result after %0d cycles, expected 4", $time, cycle - c);
            errors = errors + 1;
          end
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests

  task automatic test_exact_sums();
    int    e0;
    data_t skips[6] = '{32'h3F80_0000, 32'h4000_0000, 32'h4040_0000,
                        32'h4100_0000, 32'hC0A0_0000, 32'h3E80_0000};
    data_t mains[6] = '{32'h3F80_0000, 32'h4080_0000, 32'hC000_0000,
                        32'h4180_0000, 32'h40E0_0000, 32'h3F00_0000};
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      drive_cycle(1'b1, skips[i], 1'b0, '0);
      idle(2);
      drive_cycle(1'b0, '0, 1'b1, mains[i]);
      drain();
    end
    report_test("exact sums", e0);
  endtask

  task automatic test_burst();
    int e0;
    e0 = errors;
    for (int i = 0; i < FIFO_DEPTH; i++) drive_cycle(1'b1, rand_operand(), 1'b0, '0);
    for (int i = 0; i < FIFO_DEPTH; i++) drive_cycle(1'b0, '0, 1'b1, rand_operand());
    drain();
    report_test("burst ordering", e0);
  endtask

  task automatic test_interleaved();
    int e0;
    e0 = errors;
    // Pop from an empty buffer with the write in the same cycle
    drive_cycle(1'b1, 32'h4040_0000, 1'b1, 32'h3F80_0000);
    drive_cycle(1'b1, 32'h4120_0000, 1'b0, '0);
    drive_cycle(1'b1, 32'h4130_0000, 1'b1, 32'h3F80_0000);
    drive_cycle(1'b1, 32'h4140_0000, 1'b1, 32'h4000_0000);
    drive_cycle(1'b0, '0, 1'b1, 32'h4040_0000);
    // Buffer drained, pass-through once more
    drive_cycle(1'b1, 32'h4150_0000, 1'b1, 32'h4080_0000);
    for (int i = 0; i < 8; i++) drive_cycle(1'b1, rand_operand(), i[0], rand_operand());
    for (int i = 0; i < 4; i++) drive_cycle(1'b0, '0, 1'b1, rand_operand());
    drain();
    report_test("interleaved traffic", e0);
  endtask

  task automatic test_random_rounding();
    int    e0;
    data_t x;
    data_t y;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      x = rand_operand();
      y = rand_operand();
      // Every fourth pair nearly cancels
      if (i % 4 == 3) begin
        r = lcg_next();
        y = {~x[31], x[30:8], r[7:0]};
      end
      drive_cycle(1'b1, x, 1'b1, y);
    end
    drain();
    report_test("random rounding", e0);
  endtask

  task automatic test_specials();
    int    e0;
    data_t skips[9] = '{32'h7F80_0000, 32'hFF80_0000, 32'h7F80_0000, 32'h7FA0_0001,
                        32'h0000_0001, 32'h0000_0001, 32'h3FC0_0000, 32'h7F7F_FFFF,
                        32'h0080_0000};
    data_t mains[9] = '{32'h3F80_0000, 32'h4000_0000, 32'hFF80_0000, 32'h3F80_0000,
                        32'h3F80_0000, 32'h8000_0001, 32'hBFC0_0000, 32'h7F7F_FFFF,
                        32'h8080_0001};
    e0 = errors;
    for (int i = 0; i < 9; i++) begin
      drive_cycle(1'b1, skips[i], 1'b0, '0);
      drive_cycle(1'b0, '0, 1'b1, mains[i]);
    end
    drain();
    report_test("special values", e0);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) drive_cycle(1'b1, rand_operand(), 1'b0, '0);
    drive_cycle(1'b0, '0, 1'b1, rand_operand());
    drive_cycle(1'b0, '0, 1'b1, rand_operand());
    @(posedge clk);
    valid_in_no1 <= 1'b0;
    tb_reset     <= 1'b1;
    // Results in flight and waiting skip values are lost
    skip_model.delete();
    exp_q.delete();
    cyc_q.delete();
    repeat (2) @(posedge clk);
    // First pop would surface here if reset left the pipeline alone
    @(negedge clk);
    assert (valid_out === 1'b0)
      else begin
        $display("valid_out high while reset cut the pipeline");
        errors = errors + 1;
      end
    @(posedge clk);
    tb_reset <= 1'b0;
    idle(2);
    drive_cycle(1'b1, 32'h4000_0000, 1'b0, '0);
    drive_cycle(1'b0, '0, 1'b1, 32'h4040_0000);
    drain();
    report_test("reset mid-stream", e0);
  endtask

  initial begin
    seed         = 32'h8b8c;
    cycle        = 0;
    errors       = 0;
    checks       = 0;
    tb_reset     = 1'b0;
    valid_in_no1 = 1'b0;
    in_no1       = '0;
    valid_in_no2 = 1'b0;
    in_no2       = '0;
    wait (!reset);
    idle(2);
    test_exact_sums();
    test_burst();
    test_interleaved();
    test_random_rounding();
    test_specials();
    test_reset();
    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/cnn_add_pkg.sv
rtl/stream_delay.sv
rtl/skip_fifo.sv
rtl/fp32_add.sv
rtl/cnn_add_layer3.sv
test/tb_clock_gen.sv
test/cnn_add_layer3_assertions.sv
test/tb_cnn_add_layer3.sv

// ==== Makefile ====
TOP := tb_cnn_add_layer3

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f rtl/*.sv test/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
